//--- files.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/raster_scanner.sv
hdl/sample_fifo.sv
hdl/mem_writer.sv
hdl/raster_top.sv
testbench/raster_checker.sv
testbench/raster_monitor.sv
testbench/raster_tb.sv

//--- hdl/mem_writer.sv
// One memory word is in flight at a time; scan_start should only come once the FIFO has drained.
`timescale 1ns/1ns
`include "raster_defs.svh"

module mem_writer import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic scan_start,
	input scan_entry_t entry,
	input logic empty,
	output logic pop,
	output mem_word_t mem_word,
	output logic mem_req,
	input logic mem_ack
);

	// W_REQ holds mem_req until ack.
	// W_RELEASE waits for ack to fall, which closes the four-phase cycle.
	typedef enum logic [1:0] {
		W_IDLE,
		W_REQ,
		W_RELEASE
	} wr_state_t;

	wr_state_t state;
	logic [`RASTER_ADDR_WID-1:0] address;

	// the head entry is taken only when the memory side is quiet.
	assign pop = (state == W_IDLE) && !empty;

	// the word is loaded with the pop and then held for the whole handshake.
	// Markers and samples both pass the payload through as raw bits.
	always_ff @(posedge clk) begin
		if (pop) begin
			mem_word.is_marker <= entry.is_marker;
			mem_word.address <= address;
			mem_word.data <= entry.payload.sample;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= W_IDLE;
			mem_req <= 1'b0;
			address <= '0;
		end else begin
			case (state)
			W_IDLE: begin
				if (pop) begin
					mem_req <= 1'b1;
					state <= W_REQ;
				end
			end
			W_REQ: begin
				if (mem_ack) begin
					mem_req <= 1'b0;
					state <= W_RELEASE;
				end
			end
			W_RELEASE: begin
				// the address steps only once the handshake is fully done.
				if (!mem_ack) begin
					address <= address + 1'b1;
					state <= W_IDLE;
				end
			end
			default: begin
				mem_req <= 1'b0;
				state <= W_IDLE;
			end
			endcase

			// a new scan writes its image from address zero again.
			if (scan_start) begin
				address <= '0;
			end
		end
	end

endmodule

//--- hdl/raster_defs.svh
// Widths and codes are shared by every block; the FIFO depth must be a power of two.
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// width of the sample and line counters.
`define RASTER_SAMPLE_WID 9

// signed DAC position carried in the low bits of a DAC word.
`define RASTER_DAC_DATA_WID 20

// full DAC word, a 4-bit command on top of the position.
`define RASTER_DAC_WID 24

// DAC command codes.
// A read command is followed by a no-op word that clocks the value back.
`define RASTER_CMD_READ 4'b1001
`define RASTER_CMD_WRITE 4'b0001

// idle cycles between the read command and the read-back transfer.
`define RASTER_DAC_GAP 4'd4

// settle counter width, which also bounds RASTER_DAC_GAP.
`define RASTER_TIMER_WID 4

// ADC channel count and result width.
`define RASTER_ADC_NUM 4
`define RASTER_ADC_WID 24

// FIFO depth in entries.
`define RASTER_FIFO_DEPTH 8

// system memory address width.
`define RASTER_ADDR_WID 16

`endif

//--- hdl/raster_pkg.sv
// Entry and memory word layouts; a marker payload leaves its upper bits at zero.
`include "raster_defs.svh"

package raster_pkg;

	// a marker names the line and direction that just ended.
	// The fill keeps the marker exactly as wide as an ADC sample.
	typedef struct packed {
		logic [`RASTER_ADC_WID-`RASTER_SAMPLE_WID-2:0] fill;
		logic reverse;
		logic [`RASTER_SAMPLE_WID-1:0] line;
	} scan_marker_t;

	// the same 24 bits are either raw ADC data or a marker.
	// is_marker in the enclosing entry tells which view applies.
	typedef union packed {
		logic [`RASTER_ADC_WID-1:0] sample;
		scan_marker_t marker;
	} scan_payload_u;

	// one FIFO entry, 25 bits.
	typedef struct packed {
		logic is_marker;
		scan_payload_u payload;
	} scan_entry_t;

	// one word handed to system memory, 41 bits.
	// data is the payload as raw bits, whichever view it was built from.
	typedef struct packed {
		logic is_marker;
		logic [`RASTER_ADDR_WID-1:0] address;
		logic [`RASTER_ADC_WID-1:0] data;
	} mem_word_t;

endpackage

//--- hdl/raster_scanner.sv
// Settings are latched when arm rises; a scan always runs to its end, and adc_used must be nonzero.
`timescale 1ns/1ns
`include "raster_defs.svh"

module raster_scanner import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic arm,
	input logic [`RASTER_SAMPLE_WID-1:0] max_samples,
	input logic [`RASTER_SAMPLE_WID-1:0] max_lines,
	input logic [`RASTER_TIMER_WID-1:0] settle_time,
	input logic signed [`RASTER_DAC_DATA_WID-1:0] dx,
	input logic signed [`RASTER_DAC_DATA_WID-1:0] dy,
	input logic [`RASTER_ADC_NUM-1:0] adc_used,
	output logic running,
	output logic finished,
	output logic scan_start,
	output logic [`RASTER_DAC_WID-1:0] x_dac,
	output logic [`RASTER_DAC_WID-1:0] y_dac,
	output logic x_arm,
	output logic y_arm,
	input logic [`RASTER_DAC_WID-1:0] x_from_dac,
	input logic [`RASTER_DAC_WID-1:0] y_from_dac,
	input logic x_finished,
	input logic y_finished,
	output logic [`RASTER_ADC_NUM-1:0] adc_arm,
	input logic [`RASTER_ADC_NUM-1:0][`RASTER_ADC_WID-1:0] adc_data,
	input logic [`RASTER_ADC_NUM-1:0] adc_finished,
	output scan_entry_t entry,
	output logic push,
	input logic full
);

	localparam int CHAN_WID = $clog2(`RASTER_ADC_NUM);

	// both DAC axes share one transfer sequence.
	// dac_op records what the transfer was for, so the release state knows where to go.
	typedef enum logic [3:0] {
		S_IDLE,
		S_DAC_WAIT,
		S_DAC_RELEASE,
		S_GAP,
		S_SETTLE,
		S_MEASURE,
		S_ADC_RELEASE,
		S_SEND,
		S_MARKER,
		S_DONE
	} state_t;

	typedef enum logic [1:0] {
		OP_READ,
		OP_FETCH,
		OP_MOVE
	} dac_op_t;

	state_t state;
	dac_op_t dac_op;

	logic [`RASTER_TIMER_WID-1:0] counter;
	logic [`RASTER_SAMPLE_WID-1:0] sample_cnt;
	logic [`RASTER_SAMPLE_WID-1:0] line_cnt;
	logic [CHAN_WID-1:0] chan;
	logic is_reverse;

	// settings copied at arm so the host may change its inputs during a scan.
	logic [`RASTER_SAMPLE_WID-1:0] max_samples_q;
	logic [`RASTER_SAMPLE_WID-1:0] max_lines_q;
	logic [`RASTER_TIMER_WID-1:0] settle_time_q;
	logic signed [`RASTER_DAC_DATA_WID-1:0] dx_q;
	logic signed [`RASTER_DAC_DATA_WID-1:0] dy_q;
	logic [`RASTER_ADC_NUM-1:0] adc_used_q;

	logic signed [`RASTER_DAC_DATA_WID-1:0] x_pos;
	logic signed [`RASTER_DAC_DATA_WID-1:0] y_pos;
	logic signed [`RASTER_DAC_DATA_WID-1:0] x_next;
	logic signed [`RASTER_DAC_DATA_WID-1:0] y_next;

	logic [`RASTER_ADC_NUM-1:0][`RASTER_ADC_WID-1:0] adc_buf;

	// the next DAC position.
	// In the marker state this is the line step, (dx, dy) turned by 90 degrees.
	// Otherwise it is a sample step along the current direction.
	always_comb begin
		if (state == S_MARKER) begin
			x_next = x_pos + dy_q;
			y_next = y_pos - dx_q;
		end else if (is_reverse) begin
			x_next = x_pos - dx_q;
			y_next = y_pos - dy_q;
		end else begin
			x_next = x_pos + dx_q;
			y_next = y_pos + dy_q;
		end
	end

	// push is combinational so that full is checked in the same cycle as the write.
	// A disabled channel is skipped without a push.
	assign push = !full && ((state == S_SEND && adc_used_q[chan]) || state == S_MARKER);

	always_comb begin
		entry = '0;
		if (state == S_MARKER) begin
			entry.is_marker = 1'b1;
			entry.payload.marker.line = line_cnt;
			entry.payload.marker.reverse = is_reverse;
		end else begin
			entry.payload.sample = adc_buf[chan];
		end
	end

	// results are taken at the moment every enabled ADC reports finished.
	always_ff @(posedge clk) begin
		if (state == S_MEASURE && adc_finished == adc_arm) begin
			adc_buf <= adc_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			dac_op <= OP_READ;
			running <= 1'b0;
			finished <= 1'b0;
			scan_start <= 1'b0;
			x_arm <= 1'b0;
			y_arm <= 1'b0;
			adc_arm <= '0;
			x_dac <= '0;
			y_dac <= '0;
			counter <= '0;
			sample_cnt <= '0;
			line_cnt <= '0;
			chan <= '0;
			is_reverse <= 1'b0;
			x_pos <= '0;
			y_pos <= '0;
			max_samples_q <= '0;
			max_lines_q <= '0;
			settle_time_q <= '0;
			dx_q <= '0;
			dy_q <= '0;
			adc_used_q <= '0;
		end else begin
			scan_start <= 1'b0;
			case (state)
			S_IDLE: begin
				if (arm) begin
					max_samples_q <= max_samples;
					max_lines_q <= max_lines;
					settle_time_q <= settle_time;
					dx_q <= dx;
					dy_q <= dy;
					adc_used_q <= adc_used;
					sample_cnt <= '0;
					line_cnt <= '0;
					is_reverse <= 1'b0;
					running <= 1'b1;
					scan_start <= 1'b1;
					// ask both DACs for their present positions.
					x_dac <= {`RASTER_CMD_READ, {`RASTER_DAC_DATA_WID{1'b0}}};
					y_dac <= {`RASTER_CMD_READ, {`RASTER_DAC_DATA_WID{1'b0}}};
					x_arm <= 1'b1;
					y_arm <= 1'b1;
					dac_op <= OP_READ;
					state <= S_DAC_WAIT;
				end
			end
			S_DAC_WAIT: begin
				if (x_finished && y_finished) begin
					x_arm <= 1'b0;
					y_arm <= 1'b0;
					// the read-back transfer returns the positions in its reply.
					if (dac_op == OP_FETCH) begin
						x_pos <= x_from_dac[`RASTER_DAC_DATA_WID-1:0];
						y_pos <= y_from_dac[`RASTER_DAC_DATA_WID-1:0];
					end
					state <= S_DAC_RELEASE;
				end
			end
			S_DAC_RELEASE: begin
				// both finished bits must fall before the next arm.
				if (!x_finished && !y_finished) begin
					counter <= '0;
					if (dac_op == OP_READ) begin
						state <= S_GAP;
					end else begin
						state <= S_SETTLE;
					end
				end
			end
			S_GAP: begin
				if (counter == `RASTER_DAC_GAP) begin
					// a no-op word clocks out the value asked for by the read command.
					x_dac <= '0;
					y_dac <= '0;
					x_arm <= 1'b1;
					y_arm <= 1'b1;
					dac_op <= OP_FETCH;
					state <= S_DAC_WAIT;
				end else begin
					counter <= counter + 1'b1;
				end
			end
			S_SETTLE: begin
				if (counter == settle_time_q) begin
					adc_arm <= adc_used_q;
					state <= S_MEASURE;
				end else begin
					counter <= counter + 1'b1;
				end
			end
			S_MEASURE: begin
				if (adc_finished == adc_arm) begin
					adc_arm <= '0;
					state <= S_ADC_RELEASE;
				end
			end
			S_ADC_RELEASE: begin
				if (adc_finished == '0) begin
					chan <= CHAN_WID'(`RASTER_ADC_NUM - 1);
					state <= S_SEND;
				end
			end
			S_SEND: begin
				// walk from the highest channel down, holding while the FIFO is full.
				if (!adc_used_q[chan] || !full) begin
					if (chan != '0) begin
						chan <= chan - 1'b1;
					end else if (sample_cnt == max_samples_q) begin
						state <= S_MARKER;
					end else begin
						sample_cnt <= sample_cnt + 1'b1;
						x_pos <= x_next;
						y_pos <= y_next;
						x_dac <= {`RASTER_CMD_WRITE, x_next};
						y_dac <= {`RASTER_CMD_WRITE, y_next};
						x_arm <= 1'b1;
						y_arm <= 1'b1;
						dac_op <= OP_MOVE;
						state <= S_DAC_WAIT;
					end
				end
			end
			S_MARKER: begin
				if (!full) begin
					sample_cnt <= '0;
					if (!is_reverse) begin
						// the end point is measured again going back, without a move.
						is_reverse <= 1'b1;
						counter <= '0;
						state <= S_SETTLE;
					end else if (line_cnt == max_lines_q) begin
						running <= 1'b0;
						finished <= 1'b1;
						state <= S_DONE;
					end else begin
						is_reverse <= 1'b0;
						line_cnt <= line_cnt + 1'b1;
						x_pos <= x_next;
						y_pos <= y_next;
						x_dac <= {`RASTER_CMD_WRITE, x_next};
						y_dac <= {`RASTER_CMD_WRITE, y_next};
						x_arm <= 1'b1;
						y_arm <= 1'b1;
						dac_op <= OP_MOVE;
						state <= S_DAC_WAIT;
					end
				end
			end
			S_DONE: begin
				if (!arm) begin
					finished <= 1'b0;
					state <= S_IDLE;
				end
			end
			default: begin
				state <= S_IDLE;
			end
			endcase
		end
	end

endmodule

//--- hdl/raster_top.sv
// The DAC and ADC serial links sit outside; their ports follow a four-phase arm/finished handshake.
`timescale 1ns/1ns
`include "raster_defs.svh"

module raster_top import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic arm,
	input logic [`RASTER_SAMPLE_WID-1:0] max_samples,
	input logic [`RASTER_SAMPLE_WID-1:0] max_lines,
	input logic [`RASTER_TIMER_WID-1:0] settle_time,
	input logic signed [`RASTER_DAC_DATA_WID-1:0] dx,
	input logic signed [`RASTER_DAC_DATA_WID-1:0] dy,
	input logic [`RASTER_ADC_NUM-1:0] adc_used,
	output logic running,
	output logic finished,
	output logic [`RASTER_DAC_WID-1:0] x_dac,
	output logic [`RASTER_DAC_WID-1:0] y_dac,
	output logic x_arm,
	output logic y_arm,
	input logic [`RASTER_DAC_WID-1:0] x_from_dac,
	input logic [`RASTER_DAC_WID-1:0] y_from_dac,
	input logic x_finished,
	input logic y_finished,
	output logic [`RASTER_ADC_NUM-1:0] adc_arm,
	input logic [`RASTER_ADC_NUM-1:0][`RASTER_ADC_WID-1:0] adc_data,
	input logic [`RASTER_ADC_NUM-1:0] adc_finished,
	output mem_word_t mem_word,
	output logic mem_req,
	input logic mem_ack
);

	// the scanner and writer meet only at the FIFO and the scan start pulse.
	scan_entry_t push_entry;
	scan_entry_t pop_entry;
	logic push;
	logic full;
	logic pop;
	logic empty;
	logic scan_start;

	raster_scanner i_scanner (
		.clk(clk),
		.rst_n(rst_n),
		.arm(arm),
		.max_samples(max_samples),
		.max_lines(max_lines),
		.settle_time(settle_time),
		.dx(dx),
		.dy(dy),
		.adc_used(adc_used),
		.running(running),
		.finished(finished),
		.scan_start(scan_start),
		.x_dac(x_dac),
		.y_dac(y_dac),
		.x_arm(x_arm),
		.y_arm(y_arm),
		.x_from_dac(x_from_dac),
		.y_from_dac(y_from_dac),
		.x_finished(x_finished),
		.y_finished(y_finished),
		.adc_arm(adc_arm),
		.adc_data(adc_data),
		.adc_finished(adc_finished),
		.entry(push_entry),
		.push(push),
		.full(full)
	);

	sample_fifo i_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.entry_in(push_entry),
		.full(full),
		.pop(pop),
		.entry_out(pop_entry),
		.empty(empty)
	);

	mem_writer i_writer (
		.clk(clk),
		.rst_n(rst_n),
		.scan_start(scan_start),
		.entry(pop_entry),
		.empty(empty),
		.pop(pop),
		.mem_word(mem_word),
		.mem_req(mem_req),
		.mem_ack(mem_ack)
	);

endmodule

//--- hdl/sample_fifo.sv
// Depth must be a power of two; a push while full or a pop while empty is ignored.
`timescale 1ns/1ns
`include "raster_defs.svh"

module sample_fifo import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic push,
	input scan_entry_t entry_in,
	output logic full,
	input logic pop,
	output scan_entry_t entry_out,
	output logic empty
);

	localparam int PTR_WID = $clog2(`RASTER_FIFO_DEPTH);

	scan_entry_t buffer [`RASTER_FIFO_DEPTH];

	logic [PTR_WID-1:0] wr_ptr;
	logic [PTR_WID-1:0] rd_ptr;

	// one bit wider than the pointers so that a full buffer can be told from an empty one.
	logic [PTR_WID:0] count;

	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == (PTR_WID+1)'(`RASTER_FIFO_DEPTH));
	assign empty = (count == '0);

	// the head entry is read straight from the array, so a pushed entry shows on the next cycle.
	assign entry_out = buffer[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			buffer[wr_ptr] <= entry_in;
		end
	end

	// pointers wrap naturally because the depth is a power of two.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

endmodule

//--- testbench/raster_checker.sv
// Bound into raster_top; the failure counter is read by the testbench at the end of the run.
`timescale 1ns/1ns
`include "raster_defs.svh"

module raster_checker import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input mem_word_t mem_word,
	input logic mem_req,
	input logic mem_ack,
	input logic x_arm,
	input logic y_arm,
	input logic x_finished,
	input logic y_finished,
	input logic [`RASTER_ADC_NUM-1:0] adc_arm,
	input logic [`RASTER_ADC_NUM-1:0] adc_finished,
	input logic push,
	input logic pop,
	input logic full
);

	int failures = 0;

	// FIFO occupancy rebuilt from the push and pop strobes alone.
	// A pop only counts when something is held.
	int occupancy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			occupancy <= 0;
		end else if (push && !(pop && occupancy != 0)) begin
			occupancy <= occupancy + 1;
		end else if (!push && pop && occupancy != 0) begin
			occupancy <= occupancy - 1;
		end
	end

	// the memory word may not move while a request is open.
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable(mem_word))
	else begin
		failures++;
		$error("mem_word changed while mem_req was high");
	end

	// a new request waits for the previous ack to fall.
	assert property (@(posedge clk) disable iff (!rst_n) $rose(mem_req) |-> !$past(mem_ack))
	else begin
		failures++;
		$error("mem_req rose while mem_ack was still high");
	end

	// each DAC axis and the ADC group must see finished low before a new arm.
	assert property (@(posedge clk) disable iff (!rst_n) $rose(x_arm) |-> !$past(x_finished))
	else begin
		failures++;
		$error("x_arm rose while x_finished was still high");
	end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(y_arm) |-> !$past(y_finished))
	else begin
		failures++;
		$error("y_arm rose while y_finished was still high");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(adc_arm != '0) && ($past(adc_arm) == '0) |-> ($past(adc_finished) == '0))
	else begin
		failures++;
		$error("adc_arm rose while adc_finished was still high");
	end

	// the scanner holds its entry while the FIFO already holds a full load.
	assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (occupancy < `RASTER_FIFO_DEPTH))
	else begin
		failures++;
		$error("push asserted while the FIFO was full");
	end

	// the full flag follows the number of entries actually held.
	assert property (@(posedge clk) disable iff (!rst_n)
		full == (occupancy == `RASTER_FIFO_DEPTH))
	else begin
		failures++;
		$error("full disagrees with the number of entries in the FIFO");
	end

endmodule

bind raster_top raster_checker i_checker (
	.clk(clk),
	.rst_n(rst_n),
	.mem_word(mem_word),
	.mem_req(mem_req),
	.mem_ack(mem_ack),
	.x_arm(x_arm),
	.y_arm(y_arm),
	.x_finished(x_finished),
	.y_finished(y_finished),
	.adc_arm(adc_arm),
	.adc_finished(adc_finished),
	.push(push),
	.pop(pop),
	.full(full)
);

//--- testbench/raster_monitor.sv
// Words must be queued before they reach memory; they are compared strictly in arrival order.
`timescale 1ns/1ns
`include "raster_defs.svh"

module raster_monitor import raster_pkg::*; (
	input logic clk,
	input logic rst_n,
	input mem_word_t mem_word,
	input logic mem_req
);

	// expected words of the scans in flight, oldest first.
	mem_word_t expected [$];

	int word_errors = 0;
	int count_errors = 0;
	logic req_q;

	function void expect_word(input mem_word_t w);
		expected.push_back(w);
	endfunction

	function int words_left();
		return expected.size();
	endfunction

	// whatever is still queued never reached memory.
	function void flush_expected();
		if (expected.size() != 0) begin
			count_errors++;
			$display("%0d expected memory words never arrived", expected.size());
			expected.delete();
		end
	endfunction

	task check_word();
		mem_word_t exp;
		if (expected.size() == 0) begin
			count_errors++;
			$display("an extra memory word arrived at address %h with none expected",
				mem_word.address);
		end else begin
			exp = expected.pop_front();
			if (mem_word !== exp) begin
				word_errors++;
				$display("Fail mem_word: got marker %h address %h data %h, %s",
					mem_word.is_marker, mem_word.address, mem_word.data, "expected");
				$display("Fail mem_word: expected marker %h address %h data %h",
					exp.is_marker, exp.address, exp.data);
			end
		end
	endtask

	// the word is held for the whole handshake, so it is taken on the rising request.
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else begin
			req_q <= mem_req;
			if (mem_req && !req_q) begin
				check_word();
			end
		end
	end

endmodule

//--- testbench/raster_tb.sv
// Runs three scans with settings from a fixed-seed LCG; DAC, ADC and memory are behavioral models.
`timescale 1ns/1ns
`include "raster_defs.svh"

// one DAC axis.
// A read command returns the held position and a write command stores a new one.
module dac_model #(
	parameter int LATENCY = 2,
	parameter logic signed [`RASTER_DAC_DATA_WID-1:0] START = '0
) (
	input logic clk,
	input logic arm,
	input logic [`RASTER_DAC_WID-1:0] dac,
	output logic [`RASTER_DAC_WID-1:0] from_dac,
	output logic finished,
	output logic signed [`RASTER_DAC_DATA_WID-1:0] pos
);

	int delay = 0;

	initial begin
		pos = START;
		from_dac = '0;
		finished = 1'b0;
	end

	// inputs are read and outputs driven 1 ns after the rising edge.
	always @(posedge clk) begin
		#1;
		if (arm && !finished) begin
			if (delay == LATENCY) begin
				delay = 0;
				if (dac[`RASTER_DAC_WID-1:`RASTER_DAC_DATA_WID] == `RASTER_CMD_READ) begin
					from_dac = {4'h0, pos};
				end else if (dac[`RASTER_DAC_WID-1:`RASTER_DAC_DATA_WID] == `RASTER_CMD_WRITE) begin
					pos = dac[`RASTER_DAC_DATA_WID-1:0];
				end
				finished = 1'b1;
			end else begin
				delay++;
			end
		end else if (!arm && finished) begin
			finished = 1'b0;
		end
	end

endmodule

module raster_tb import raster_pkg::*; ();

	localparam int SCAN_LIMIT = 20000;
	localparam int DRAIN_LIMIT = 5000;
	localparam int RELEASE_LIMIT = 20;

	logic clk = 1'b0;
	logic rst_n;
	logic arm;
	logic [`RASTER_SAMPLE_WID-1:0] max_samples;
	logic [`RASTER_SAMPLE_WID-1:0] max_lines;
	logic [`RASTER_TIMER_WID-1:0] settle_time;
	logic signed [`RASTER_DAC_DATA_WID-1:0] dx;
	logic signed [`RASTER_DAC_DATA_WID-1:0] dy;
	logic [`RASTER_ADC_NUM-1:0] adc_used;
	logic running;
	logic finished;
	logic [`RASTER_DAC_WID-1:0] x_dac;
	logic [`RASTER_DAC_WID-1:0] y_dac;
	logic x_arm;
	logic y_arm;
	logic [`RASTER_DAC_WID-1:0] x_from_dac;
	logic [`RASTER_DAC_WID-1:0] y_from_dac;
	logic x_finished;
	logic y_finished;
	logic signed [`RASTER_DAC_DATA_WID-1:0] x_pos;
	logic signed [`RASTER_DAC_DATA_WID-1:0] y_pos;
	logic [`RASTER_ADC_NUM-1:0] adc_arm;
	logic [`RASTER_ADC_NUM-1:0][`RASTER_ADC_WID-1:0] adc_data;
	logic [`RASTER_ADC_NUM-1:0] adc_finished;
	mem_word_t mem_word;
	logic mem_req;
	logic mem_ack;

	logic [31:0] cfg_seed = 32'd51477;
	logic [31:0] mem_seed = 32'd51477;
	int adc_delay = 0;
	int ack_delay = 0;
	logic ack_pending = 1'b0;
	int control_errors = 0;
	logic stalled = 1'b0;
	int total;

	always #5 clk = ~clk;

	raster_top i_dut (.*);

	// the two axes answer with different latencies so that the scanner must wait for both.
	dac_model #(.LATENCY(2), .START(20'sd1000)) i_x_dac (
		.clk(clk), .arm(x_arm), .dac(x_dac), .from_dac(x_from_dac),
		.finished(x_finished), .pos(x_pos)
	);

	dac_model #(.LATENCY(3), .START(-20'sd500)) i_y_dac (
		.clk(clk), .arm(y_arm), .dac(y_dac), .from_dac(y_from_dac),
		.finished(y_finished), .pos(y_pos)
	);

	raster_monitor i_monitor (.clk(clk), .rst_n(rst_n), .mem_word(mem_word), .mem_req(mem_req));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] draw_cfg();
		cfg_seed = lcg_next(cfg_seed);
		return cfg_seed[31:16];
	endfunction

	// channel number in the top bits, the low bits of both positions below.
	function automatic logic [`RASTER_ADC_WID-1:0] adc_value(input int chan,
		input logic signed [`RASTER_DAC_DATA_WID-1:0] x, input logic signed [`RASTER_DAC_DATA_WID-1:0] y);
		logic [1:0] ch;
		ch = chan[1:0];
		return {ch, x[10:0], y[10:0]};
	endfunction

	// the expected image, walked point by point from the start position.
	// Forward then backward per line, then a line step of (dy, -dx).
	function automatic void build_expected(input logic [`RASTER_SAMPLE_WID-1:0] ms,
		input logic [`RASTER_SAMPLE_WID-1:0] ml, input logic signed [`RASTER_DAC_DATA_WID-1:0] sdx,
		input logic signed [`RASTER_DAC_DATA_WID-1:0] sdy, input logic [`RASTER_ADC_NUM-1:0] used,
		input logic signed [`RASTER_DAC_DATA_WID-1:0] x0,
		input logic signed [`RASTER_DAC_DATA_WID-1:0] y0);
		logic signed [`RASTER_DAC_DATA_WID-1:0] x;
		logic signed [`RASTER_DAC_DATA_WID-1:0] y;
		logic [`RASTER_ADDR_WID-1:0] addr;
		mem_word_t w;
		int line;
		int dir;
		int s;
		int c;
		x = x0;
		y = y0;
		addr = '0;
		for (line = 0; line <= ml; line++) begin
			for (dir = 0; dir < 2; dir++) begin
				for (s = 0; s <= ms; s++) begin
					for (c = `RASTER_ADC_NUM - 1; c >= 0; c--) begin
						if (used[c]) begin
							w.is_marker = 1'b0;
							w.address = addr;
							w.data = adc_value(c, x, y);
							i_monitor.expect_word(w);
							addr++;
						end
					end
					if (s < ms && dir == 0) begin
						x = x + sdx;
						y = y + sdy;
					end else if (s < ms) begin
						x = x - sdx;
						y = y - sdy;
					end
				end
				// marker payload is the line in the low bits and the reverse flag above it.
				w.is_marker = 1'b1;
				w.address = addr;
				w.data = '0;
				w.data[`RASTER_SAMPLE_WID-1:0] = line[`RASTER_SAMPLE_WID-1:0];
				w.data[`RASTER_SAMPLE_WID] = dir[0];
				i_monitor.expect_word(w);
				addr++;
			end
			x = x + sdy;
			y = y - sdx;
		end
	endfunction

	// ADC group answers every armed channel at once.
	always @(posedge clk) begin
		#1;
		if (adc_arm != '0 && adc_finished == '0) begin
			if (adc_delay == 3) begin
				adc_delay = 0;
				for (int c = 0; c < `RASTER_ADC_NUM; c++) begin
					adc_data[c] = adc_value(c, x_pos, y_pos);
				end
				adc_finished = adc_arm;
			end else begin
				adc_delay++;
			end
		end else if (adc_arm == '0 && adc_finished != '0) begin
			adc_finished = '0;
		end
	end

	// memory acks after a random 0 to 15 cycles, often slow enough to fill the FIFO.
	always @(posedge clk) begin
		#1;
		if (mem_req && !mem_ack) begin
			if (!ack_pending) begin
				mem_seed = lcg_next(mem_seed);
				ack_delay = mem_seed[19:16];
				ack_pending = 1'b1;
			end
			if (ack_delay == 0) begin
				mem_ack = 1'b1;
				ack_pending = 1'b0;
			end else begin
				ack_delay--;
			end
		end else if (!mem_req && mem_ack) begin
			mem_ack = 1'b0;
		end
	end

	task automatic run_scan();
		int cycles;
		logic [15:0] r;
		logic ran_low;
		logic dropped;
		@(posedge clk);
		#1;
		max_samples = `RASTER_SAMPLE_WID'(draw_cfg() % 4);
		max_lines = `RASTER_SAMPLE_WID'(draw_cfg() % 3);
		settle_time = `RASTER_TIMER_WID'(draw_cfg() % 4);
		r = draw_cfg();
		dx = {{8{r[11]}}, r[11:0]};
		r = draw_cfg();
		dy = {{8{r[11]}}, r[11:0]};
		adc_used = `RASTER_ADC_NUM'(draw_cfg() % 15 + 1);
		build_expected(max_samples, max_lines, dx, dy, adc_used, x_pos, y_pos);
		arm = 1'b1;
		cycles = 0;
		ran_low = 1'b0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (!finished && !running) begin
				ran_low = 1'b1;
			end
		end while (!finished && cycles < SCAN_LIMIT);
		if (!finished) begin
			control_errors++;
			stalled = 1'b1;
			$display("timeout: finished did not rise within %0d cycles", SCAN_LIMIT);
			return;
		end
		if (running) begin
			control_errors++;
			$display("Fail running: got %h, expected %h", running, 1'b0);
		end
		if (ran_low) begin
			control_errors++;
			$display("running was low while the scan was still in progress");
		end
		// the FIFO may still hold words, so memory is drained with arm held high.
		cycles = 0;
		dropped = 1'b0;
		while ((i_monitor.words_left() != 0 || mem_req || mem_ack) && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
			if (!finished) begin
				dropped = 1'b1;
			end
		end
		if (i_monitor.words_left() != 0 || mem_req || mem_ack) begin
			control_errors++;
			stalled = 1'b1;
			$display("timeout: memory writes did not complete within %0d cycles", DRAIN_LIMIT);
			i_monitor.flush_expected();
			return;
		end
		if (dropped || !finished) begin
			control_errors++;
			$display("finished fell while arm was still high");
		end
		arm = 1'b0;
		cycles = 0;
		while (finished && cycles < RELEASE_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (finished) begin
			control_errors++;
			stalled = 1'b1;
			$display("timeout: finished stayed high after arm fell");
		end
	endtask

	initial begin
		rst_n = 1'b0;
		arm = 1'b0;
		max_samples = '0;
		max_lines = '0;
		settle_time = '0;
		dx = '0;
		dy = '0;
		adc_used = '0;
		adc_data = '0;
		adc_finished = '0;
		mem_ack = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int scan = 0; scan < 3 && !stalled; scan++) begin
			run_scan();
		end
		i_monitor.flush_expected();
		total = i_monitor.word_errors + i_monitor.count_errors + control_errors
			+ i_dut.i_checker.failures;
		$display("errors: %0d word, %0d count, %0d control, %0d assertion",
			i_monitor.word_errors, i_monitor.count_errors, control_errors,
			i_dut.i_checker.failures);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
